//--- spim.f
+incdir+logic
logic/spim_pkg.sv
logic/spim_xfer_if.sv
logic/spim_clkgen.sv
logic/spim_arbiter.sv
logic/spim_engine.sv
logic/spim_top.sv
test/spim_tb_clock.sv
test/spim_chk.sv
test/spim_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the spi master testbench with verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f spim.f --top-module spim_tb -o spim_sim \
    && ./obj_dir/spim_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "Verification passed" sim.log && exit 0 || exit 1

//--- test/spim_tb.sv
`timescale 1ns/1ps
`default_nettype none

module spim_tb;
    import spim_pkg::*;

    localparam int PHASES      = 6;
    localparam int PER_PHASE   = 12;
    // system clock period in ns
    localparam int CLK_NS      = 10;
    // 200 transfers x 8 bits x largest period x 2 margin
    localparam int MAX_CYCLES  = 200 * 8 * 8 * 2;

    logic         clk;
    logic         rstn;
    spim_period_t cfg;
    logic [1:0]   req;
    logic [1:0]   done_w;
    spim_data_t   wdata [2];
    spim_data_t   rdata_w [2];
    logic         sck;
    logic         cs_n;
    logic         mosi;
    logic         miso;

    int unsigned  lcg_state = 32'd76761;
    int           err_data;
    int           err_rdata;
    int           err_order;
    int           err_bus;
    int           err_assert;
    int           cycles;
    // slave side state
    spim_data_t   rx_sr;
    spim_data_t   reply_sr;
    spim_data_t   slave_reply;
    spim_data_t   captured;
    int           fall_cnt;
    longint       last_edge_t;
    // reference model state
    spim_data_t   model_reply;
    bit           contend;
    bit           have_last;
    int           last_id;

    spim_tb_clock u_clock (
        .clk  (clk),
        .rstn (rstn)
    );

    spim_top u_spim_top (
        .clk            (clk),
        .rstn           (rstn),
        .cfg_sck_period (cfg),
        .req_a          (req[0]),
        .wdata_a        (wdata[0]),
        .done_a         (done_w[0]),
        .rdata_a        (rdata_w[0]),
        .req_b          (req[1]),
        .wdata_b        (wdata[1]),
        .done_b         (done_w[1]),
        .rdata_b        (rdata_w[1]),
        .sck            (sck),
        .cs_n           (cs_n),
        .mosi           (mosi),
        .miso           (miso)
    );

    // 32 bit lcg returning its upper bits
    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;
    endfunction

    ////////////////////////////////////////////////////////////
    // slave model replying with the inverse of the last byte
    ////////////////////////////////////////////////////////////

    // edges inside a frame are half a period apart
    task automatic check_edge_gap();
        longint now;
        longint exp_gap;
        now     = longint'($time);
        exp_gap = longint'(cfg) / 2 * CLK_NS;
        if (last_edge_t >= 0 && now - last_edge_t != exp_gap) begin
            err_bus++;
            $display("FAIL t=%0t sck_edge_gap got %0d exp %0d", $time,
                     now - last_edge_t, exp_gap);
        end
        last_edge_t = now;
    endtask

    always @(negedge cs_n) begin
        reply_sr    = slave_reply;
        fall_cnt    = 0;
        last_edge_t = -1;
    end

    // drive next reply bit for the engine's rise pulse sample
    always @(negedge sck) begin
        if (!cs_n) begin
            miso     <= reply_sr[7];
            reply_sr  = {reply_sr[6:0], 1'b0};
            fall_cnt++;
            check_edge_gap();
        end
    end

    always @(posedge sck) begin
        if (!cs_n) begin
            rx_sr = {rx_sr[6:0], mosi};
            check_edge_gap();
        end
    end

    always @(posedge cs_n) begin
        if (rstn) begin
            if (fall_cnt != 8) begin
                err_bus++;
                $display("FAIL t=%0t sck_fall_count got %0d exp 8", $time, fall_cnt);
            end
            captured    = rx_sr;
            slave_reply = ~rx_sr;
        end
    end

    ////////////////////////////////////////////////////////////
    // cycle monitor and timeout
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycles++;
        if (rstn && cs_n && !sck) begin
            err_bus++;
            $display("sck low between transfers at t=%0t", $time);
        end
        if (done_w[0] && !req[0] || done_w[1] && !req[1]) begin
            err_order++;
            $display("done pulse without an open request at t=%0t", $time);
        end
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, transfers did not complete", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // requesters and reference checks
    ////////////////////////////////////////////////////////////

    task automatic score_transfer(input int id, input spim_data_t sent);
        if (captured != sent) begin
            err_data++;
            $display("FAIL t=%0t mosi_byte_%s got %h exp %h", $time,
                     id == 0 ? "a" : "b", captured, sent);
        end
        if (rdata_w[id] != model_reply) begin
            err_rdata++;
            $display("FAIL t=%0t rdata_%s got %h exp %h", $time,
                     id == 0 ? "a" : "b", rdata_w[id], model_reply);
        end
        model_reply = ~sent;
        // under contention the two must take turns
        if (contend && have_last && last_id == id) begin
            err_order++;
            $display("requester %s served twice in a row while the other waited",
                     id == 0 ? "a" : "b");
        end
        last_id   = id;
        have_last = 1'b1;
    endtask

    // level request held until its done pulse
    // under contention it stays high straight into the next byte
    task automatic run_requester(input int id, input int count);
        int         n;
        int         delay;
        spim_data_t byte_v;
        for (n = 0; n < count; n++) begin
            byte_v = spim_data_t'(lcg_next());
            if (!contend) begin
                delay = int'(lcg_next() % 12);
                repeat (delay) @(posedge clk);
            end
            if (!contend || n == 0) begin
                @(posedge clk);
            end
            req[id]   <= 1'b1;
            wdata[id] <= byte_v;
            @(posedge clk);
            while (!done_w[id]) @(posedge clk);
            score_transfer(id, byte_v);
            if (!contend || n == count - 1) begin
                req[id] <= 1'b0;
            end
        end
    endtask

    initial begin
        int p;
        cfg         = spim_period_t'(8);
        req         = 2'b00;
        wdata[0]    = '0;
        wdata[1]    = '0;
        miso        = 1'b1;
        slave_reply = 8'hFF;
        model_reply = 8'hFF;
        err_data    = 0;
        err_rdata   = 0;
        err_order   = 0;
        err_bus     = 0;
        err_assert  = 0;
        cycles      = 0;
        @(posedge rstn);
        for (p = 0; p < PHASES; p++) begin
            // divider only changes with every request low
            @(posedge clk);
            case (lcg_next() % 3)
                0: cfg <= spim_period_t'(4);
                1: cfg <= spim_period_t'(6);
                default: cfg <= spim_period_t'(8);
            endcase
            // odd phases keep both requests up back to back
            contend   = p[0];
            have_last = 1'b0;
            repeat (2) @(posedge clk);
            fork
                run_requester(0, PER_PHASE);
                run_requester(1, PER_PHASE);
            join
        end
        repeat (4) @(posedge clk);
        err_assert = int'(u_spim_top.u_chk.fail_cnt);
        $display("errors: data %0d rdata %0d order %0d bus %0d assert %0d",
                 err_data, err_rdata, err_order, err_bus, err_assert);
        if (err_data + err_rdata + err_order + err_bus + err_assert == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/spim_chk.sv
`timescale 1ns/1ps
`default_nettype none

module spim_chk (
    input wire logic clk,
    input wire logic rstn,
    input wire logic sck,
    input wire logic cs_n,
    input wire logic done_a,
    input wire logic done_b
);

    // assertion failures so far
    int unsigned fail_cnt = 0;

    ////////////////////////////////////////////////////////////
    // spi pin rules
    ////////////////////////////////////////////////////////////

    // no sck activity outside a frame with clock polarity high
    sck_idle_high: assert property (
        @(posedge clk) disable iff (!rstn) cs_n |-> sck
    ) else begin
        fail_cnt++;
        $error("sck low while cs_n high");
    end

    // first sampled cycle out of reset keeps the slave deselected
    cs_idle_after_reset: assert property (
        @(posedge clk) $rose(rstn) |-> cs_n
    ) else begin
        fail_cnt++;
        $error("cs_n low right after reset");
    end

    ////////////////////////////////////////////////////////////
    // result routing
    ////////////////////////////////////////////////////////////

    // only the owner of the engine sees done
    done_one_hot: assert property (
        @(posedge clk) disable iff (!rstn) !(done_a && done_b)
    ) else begin
        fail_cnt++;
        $error("done_a and done_b high together");
    end

endmodule

bind spim_top spim_chk u_chk (
    .clk    (clk),
    .rstn   (rstn),
    .sck    (sck),
    .cs_n   (cs_n),
    .done_a (done_a),
    .done_b (done_b)
);

`default_nettype wire

//--- test/spim_tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

// system clock and power on reset for the testbench
module spim_tb_clock (
    output logic clk,
    output logic rstn
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for five rising edges, released on an edge
    initial begin
        rstn = 1'b0;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

`default_nettype wire

//--- logic/spim_top.sv
`timescale 1ns/1ps
`default_nettype none

module spim_top (
    input  logic                  clk,
    input  logic                  rstn,
    input  spim_pkg::spim_period_t cfg_sck_period,
    // requester a
    input  logic                  req_a,
    input  spim_pkg::spim_data_t   wdata_a,
    output logic                  done_a,
    output spim_pkg::spim_data_t   rdata_a,
    // requester b
    input  logic                  req_b,
    input  spim_pkg::spim_data_t   wdata_b,
    output logic                  done_b,
    output spim_pkg::spim_data_t   rdata_b,
    // spi pins
    output logic                  sck,
    output logic                  cs_n,
    output logic                  mosi,
    input  logic                  miso
);

    logic sck_en;
    logic spi_fall;
    logic spi_rise;

    // granted transfer from arbiter to engine
    spim_xfer_if u_xfer ();

    ////////////////////////////////////////////////////////////
    // request side
    ////////////////////////////////////////////////////////////

    spim_arbiter u_arbiter (
        .clk     (clk),
        .rstn    (rstn),
        .req_a   (req_a),
        .req_b   (req_b),
        .wdata_a (wdata_a),
        .wdata_b (wdata_b),
        .done_a  (done_a),
        .done_b  (done_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .xfer    (u_xfer)
    );

    ////////////////////////////////////////////////////////////
    // serial side
    ////////////////////////////////////////////////////////////

    spim_engine u_engine (
        .clk      (clk),
        .rstn     (rstn),
        .xfer     (u_xfer),
        .spi_fall (spi_fall),
        .spi_rise (spi_rise),
        .sck_en   (sck_en),
        .cs_n     (cs_n),
        .mosi     (mosi),
        .miso     (miso)
    );

    // sck pin comes straight from the generator register
    spim_clkgen u_clkgen (
        .clk            (clk),
        .rstn           (rstn),
        .en             (sck_en),
        .cfg_sck_period (cfg_sck_period),
        .spi_clk        (sck),
        .spi_fall       (spi_fall),
        .spi_rise       (spi_rise)
    );

endmodule

`default_nettype wire

//--- logic/spim_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "spim_params.svh"

module spim_engine (
    input  logic     clk,
    input  logic     rstn,
    spim_xfer_if.eng xfer,
    input  logic     spi_fall,
    input  logic     spi_rise,
    output logic     sck_en,
    output logic     cs_n,
    output logic     mosi,
    input  logic     miso
);
    import spim_pkg::*;

    localparam int unsigned BIT_CNT_W = $clog2(`SPIM_DATA_W);
    localparam int unsigned MSB       = `SPIM_DATA_W - 1;

    spim_state_e            state;
    logic [BIT_CNT_W-1:0]   bit_cnt;
    logic                   busy_q;
    logic                   done_q;
    spim_data_t             tx_sr;
    spim_data_t             rx_sr;
    logic                   last_bit;

    // eighth sample of the frame
    assign last_bit = (bit_cnt == BIT_CNT_W'(MSB));

    ////////////////////////////////////////////////////////////
    // control fsm
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= IDLE;
            bit_cnt <= '0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            cs_n    <= 1'b1;
            sck_en  <= 1'b0;
            mosi    <= 1'b0;
        end else begin
            // done is a single cycle pulse
            done_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (xfer.start) begin
                        busy_q <= 1'b1;
                        state  <= SYNC;
                    end
                end
                SYNC: begin
                    // open the frame on a fall pulse so sck starts
                    // a clean half period later
                    if (spi_fall) begin
                        cs_n    <= 1'b0;
                        sck_en  <= 1'b1;
                        mosi    <= xfer.tx_data[MSB];
                        bit_cnt <= '0;
                        state   <= SHIFT;
                    end
                end
                SHIFT: begin
                    // next bit goes out on each fall pulse
                    if (spi_fall) begin
                        mosi <= tx_sr[MSB];
                    end
                    // count samples taken on rise pulses
                    if (spi_rise) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (last_bit) begin
                            state <= FINISH;
                        end
                    end
                end
                FINISH: begin
                    // sck is already back high here
                    if (spi_fall) begin
                        cs_n   <= 1'b1;
                        sck_en <= 1'b0;
                        busy_q <= 1'b0;
                        done_q <= 1'b1;
                        state  <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // data shift registers
    ////////////////////////////////////////////////////////////

    // tx holds the bits still to send, msb aligned
    // msb itself leaves straight from tx_data when the frame opens
    always_ff @(posedge clk) begin
        if (state == SYNC && spi_fall) begin
            tx_sr <= {xfer.tx_data[MSB-1:0], 1'b0};
        end else if (state == SHIFT && spi_fall) begin
            tx_sr <= {tx_sr[MSB-1:0], 1'b0};
        end
    end

    // rx fills from the lsb side, first sample ends up at the msb
    always_ff @(posedge clk) begin
        if (state == SHIFT && spi_rise) begin
            rx_sr <= {rx_sr[MSB-1:0], miso};
        end
    end

    assign xfer.busy    = busy_q;
    assign xfer.done    = done_q;
    assign xfer.rx_data = rx_sr;

endmodule

`default_nettype wire

//--- logic/spim_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module spim_arbiter (
    input  logic                clk,
    input  logic                rstn,
    input  logic                req_a,
    input  logic                req_b,
    input  spim_pkg::spim_data_t wdata_a,
    input  spim_pkg::spim_data_t wdata_b,
    output logic                done_a,
    output logic                done_b,
    output spim_pkg::spim_data_t rdata_a,
    output spim_pkg::spim_data_t rdata_b,
    spim_xfer_if.arb            xfer
);
    import spim_pkg::*;

    localparam spim_req_idx_t REQ_A = 1'b0;
    localparam spim_req_idx_t REQ_B = 1'b1;

    // current owner, doubles as the last served index
    spim_req_idx_t grant_q;
    spim_req_idx_t pick;
    logic          pending_q;
    logic          start_q;
    logic          grant_go;
    spim_data_t    tx_q;

    ////////////////////////////////////////////////////////////
    // round robin choice
    ////////////////////////////////////////////////////////////

    // under contention the requester not served last wins
    always_comb begin
        if (req_a && req_b) begin
            pick = ~grant_q;
        end else if (req_b) begin
            pick = REQ_B;
        end else begin
            pick = REQ_A;
        end
    end

    // engine free and no transfer of ours still in flight
    assign grant_go = (req_a || req_b) && !pending_q && !xfer.busy;

    ////////////////////////////////////////////////////////////
    // grant and start
    ////////////////////////////////////////////////////////////

    // pending spans start to done so a held req is not re-granted
    // reset owner is b, so a goes first
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            start_q   <= 1'b0;
            pending_q <= 1'b0;
            grant_q   <= REQ_B;
        end else begin
            start_q <= 1'b0;
            if (grant_go) begin
                start_q   <= 1'b1;
                pending_q <= 1'b1;
                grant_q   <= pick;
            end else if (xfer.done) begin
                pending_q <= 1'b0;
            end
        end
    end

    // byte captured with the grant, stable until done
    always_ff @(posedge clk) begin
        if (grant_go) begin
            tx_q <= (pick == REQ_A) ? wdata_a : wdata_b;
        end
    end

    assign xfer.start   = start_q;
    assign xfer.tx_data = tx_q;

    ////////////////////////////////////////////////////////////
    // result routing
    ////////////////////////////////////////////////////////////

    // only the owner sees done and the received byte
    assign done_a  = xfer.done && (grant_q == REQ_A);
    assign done_b  = xfer.done && (grant_q == REQ_B);
    assign rdata_a = (grant_q == REQ_A) ? xfer.rx_data : '0;
    assign rdata_b = (grant_q == REQ_B) ? xfer.rx_data : '0;

endmodule

`default_nettype wire

//--- logic/spim_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module spim_clkgen (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  en,
    input  spim_pkg::spim_period_t cfg_sck_period,
    output logic                  spi_clk,
    output logic                  spi_fall,
    output logic                  spi_rise
);
    import spim_pkg::*;

    spim_period_t half_period;
    spim_period_t clk_cnt;

    // half of the programmed period, setting is even
    assign half_period = cfg_sck_period >> 1;

    ////////////////////////////////////////////////////////////
    // serial clock
    ////////////////////////////////////////////////////////////

    // low for the second half of each period while enabled
    // first low phase starts at the half point after en rises
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            spi_clk <= 1'b1;
        end else if (!en) begin
            // idle level, clock polarity high
            spi_clk <= 1'b1;
        end else if (clk_cnt == half_period) begin
            spi_clk <= 1'b0;
        end else if (clk_cnt == cfg_sck_period) begin
            spi_clk <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // free running phase pulses
    ////////////////////////////////////////////////////////////

    // counter runs 1..period regardless of en
    // rise pulse at the half point, fall pulse at the wrap
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            clk_cnt  <= spim_period_t'(1);
            spi_fall <= 1'b0;
            spi_rise <= 1'b0;
        end else if (clk_cnt == half_period) begin
            clk_cnt  <= clk_cnt + 1'b1;
            spi_fall <= 1'b0;
            spi_rise <= 1'b1;
        end else if (clk_cnt == cfg_sck_period) begin
            // wrap back to the start of the period
            clk_cnt  <= spim_period_t'(1);
            spi_fall <= 1'b1;
            spi_rise <= 1'b0;
        end else begin
            clk_cnt  <= clk_cnt + 1'b1;
            spi_fall <= 1'b0;
            spi_rise <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/spim_xfer_if.sv
`timescale 1ns/1ps
`default_nettype none

// one granted transfer between the arbiter and the shift engine
interface spim_xfer_if;
    import spim_pkg::*;

    // one cycle pulse from the arbiter
    logic       start;
    // held stable from start until done
    spim_data_t tx_data;
    // engine level, high from the cycle after start until done
    logic       busy;
    // single cycle end of transfer marker
    logic       done;
    // received byte, only meaningful while done is high
    spim_data_t rx_data;

    modport arb (
        output start,
        output tx_data,
        input  busy,
        input  done,
        input  rx_data
    );

    modport eng (
        input  start,
        input  tx_data,
        output busy,
        output done,
        output rx_data
    );

endinterface

`default_nettype wire

//--- logic/spim_pkg.sv
`default_nettype none

`include "spim_params.svh"

package spim_pkg;

    ////////////////////////////////////////////////////////////
    // payload and configuration types
    ////////////////////////////////////////////////////////////

    // one transfer byte, shifted msb first
    typedef logic [`SPIM_DATA_W-1:0] spim_data_t;

    // system clocks per serial clock period
    typedef logic [`SPIM_PERIOD_W-1:0] spim_period_t;

    // index of the requester that owns the engine
    typedef logic [$clog2(`SPIM_NUM_REQ)-1:0] spim_req_idx_t;

    ////////////////////////////////////////////////////////////
    // engine fsm
    ////////////////////////////////////////////////////////////

    // idle   waiting for a start from the arbiter
    // sync   lining up with the next fall pulse
    // shift  moving the eight data bits
    // finish waiting for the fall pulse that closes the frame
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        SYNC   = 2'd1,
        SHIFT  = 2'd2,
        FINISH = 2'd3
    } spim_state_e;

endpackage

`default_nettype wire

//--- logic/spim_params.svh
`ifndef SPIM_PARAMS_SVH
`define SPIM_PARAMS_SVH

////////////////////////////////////////////////////////////
// spi master build constants
////////////////////////////////////////////////////////////

// bits moved per transfer, one byte
`define SPIM_DATA_W 8

// width of the divider setting in system clocks
// the setting must be even and at least 4
`define SPIM_PERIOD_W 6

// requesters sharing the engine
// the arbiter logic is written for exactly two
`define SPIM_NUM_REQ 2

`endif
